//--- verilog/gating_pkg.sv
// Shared widths, lane counts, enable struct and lane word structs for the gating network
package gating_pkg;

    // ====================
    // Widths and lane counts
    // ====================

    // Data bus and result width
    localparam int data_w = 32;

    // Processing branch, four byte-wide units
    localparam int proc_lanes  = 4;
    localparam int proc_lane_w = 8;

    // Memory branch, two half-word units
    localparam int mem_lanes  = 2;
    localparam int mem_lane_w = 16;

    // ====================
    // Enable bundle
    // ====================

    // All gate enables, 11 bits, global gate in the top bit
    typedef struct packed {
        logic                  global_en;
        logic                  proc_en;
        logic                  mem_en;
        logic                  io_en;
        logic                  ctrl_en;
        // One bit per processing unit
        logic [proc_lanes-1:0] proc_unit_en;
        // One bit per memory unit
        logic [mem_lanes-1:0]  mem_unit_en;
    } gate_en_t;

    // ====================
    // Lane words
    // ====================

    // Four processing units, unit 3 in the top byte
    typedef struct packed {
        logic [proc_lanes-1:0][proc_lane_w-1:0] lane;
    } proc_word_t;

    // Two memory units, unit 1 in the top half
    typedef struct packed {
        logic [mem_lanes-1:0][mem_lane_w-1:0] lane;
    } mem_word_t;

endpackage

//--- verilog/proc_branch.sv
// Processing branch: four enable-gated byte units loading data byte plus unit index
module proc_branch import gating_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  gate_en_t            gate_en,
    input  logic [data_w-1:0]   data_in,
    output proc_word_t          proc_q
);

    // ====================
    // Unit storage
    // ====================

    // One register per unit, packed onto proc_q below
    logic [proc_lane_w-1:0] unit_q [proc_lanes];

    // Full chain per unit: global, block, unit
    logic [proc_lanes-1:0]  unit_load;

    // ====================
    // Unit registers
    // ====================

    for (genvar i = 0; i < proc_lanes; i++) begin : gen_unit

        // Inferred gate, all three levels must be open
        assign unit_load[i] = gate_en.global_en
                            & gate_en.proc_en
                            & gate_en.proc_unit_en[i];

        // Byte i of the bus plus the unit index, wraps at 256
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                unit_q[i] <= '0;
            end else if (unit_load[i]) begin
                unit_q[i] <= data_in[i*proc_lane_w +: proc_lane_w]
                           + proc_lane_w'(i);
            end
        end

        // Unit i lands in byte i of the word
        assign proc_q.lane[i] = unit_q[i];

        // Closed chain means the unit holds across the edge
        a_unit_hold: assert property (
            @(posedge clk) disable iff (!rst_n)
            !unit_load[i] |=> $stable(unit_q[i])
        ) else $error("proc unit %0d changed with its gate closed", i);

    end

endmodule

//--- verilog/mem_branch.sv
// Memory branch: two enable-gated half-word units loading their half of the data bus
module mem_branch import gating_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  gate_en_t            gate_en,
    input  logic [data_w-1:0]   data_in,
    output mem_word_t           mem_q
);

    // ====================
    // Unit storage
    // ====================

    // Half-word registers, unit 1 ends up in the top half
    logic [mem_lane_w-1:0] unit_q [mem_lanes];

    // Global, memory and unit enable chain
    logic [mem_lanes-1:0]  unit_load;

    // ====================
    // Unit registers
    // ====================

    for (genvar j = 0; j < mem_lanes; j++) begin : gen_unit

        // Gate opens only when the whole chain is set
        assign unit_load[j] = gate_en.global_en
                            & gate_en.mem_en
                            & gate_en.mem_unit_en[j];

        // Straight capture of half j
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                unit_q[j] <= '0;
            end else if (unit_load[j]) begin
                unit_q[j] <= data_in[j*mem_lane_w +: mem_lane_w];
            end
        end

        // Pack onto the branch output
        assign mem_q.lane[j] = unit_q[j];

        // Held value whenever the chain is off
        a_unit_hold: assert property (
            @(posedge clk) disable iff (!rst_n)
            !unit_load[j] |=> $stable(unit_q[j])
        ) else $error("mem unit %0d changed with its gate closed", j);

    end

endmodule

//--- verilog/ctrl_io_combine.sv
// IO register, control capture of the processing word and the XOR result stage
module ctrl_io_combine import gating_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  gate_en_t            gate_en,
    input  logic [data_w-1:0]   data_in,
    input  proc_word_t          proc_q,
    input  mem_word_t           mem_q,
    output logic [data_w-1:0]   data_out
);

    // ====================
    // Local state
    // ====================

    // IO block, full bus capture
    logic [data_w-1:0] io_q;

    // Control block, snapshot of the processing units
    proc_word_t        ctrl_q;

    // Gate terms for the two registers here
    logic              io_load;
    logic              ctrl_load;

    assign io_load   = gate_en.global_en & gate_en.io_en;
    assign ctrl_load = gate_en.global_en & gate_en.ctrl_en;

    // ====================
    // IO register
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_q <= '0;
        end else if (io_load) begin
            io_q <= data_in;
        end
    end

    // ====================
    // Control capture
    // ====================

    // Takes proc_q as it was before this edge,
    // so a unit update needs a second enabled edge to show up here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (ctrl_load) begin
            ctrl_q <= proc_q;
        end
    end

    // ====================
    // Result
    // ====================

    // Pure XOR of three register sets, no extra stage
    assign data_out = ctrl_q ^ io_q ^ mem_q;

    // ====================
    // Checks
    // ====================

    // Every bit resolved once out of reset, memory side included
    a_out_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(data_out)
    ) else $error("data_out has unknown bits");

    // Control snapshot frozen while its gate is closed
    a_ctrl_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !ctrl_load |=> $stable(ctrl_q)
    ) else $error("control register changed with ctrl gate closed");

endmodule

//--- verilog/multiblock_gating.sv
// Top level of the multiblock gating network: processing, memory and combining stage
module multiblock_gating import gating_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  gate_en_t            gate_en,
    input  logic [data_w-1:0]   data_in,
    output logic [data_w-1:0]   data_out
);

    // ====================
    // Branch outputs
    // ====================

    // Processing units toward the control capture
    proc_word_t proc_q;

    // Memory units toward the XOR stage
    mem_word_t  mem_q;

    // ====================
    // Processing branch
    // ====================

    // Four byte units, result visible after a later ctrl edge
    proc_branch u_proc (
        .clk     (clk),
        .rst_n   (rst_n),
        .gate_en (gate_en),
        .data_in (data_in),
        .proc_q  (proc_q)
    );

    // ====================
    // Memory branch
    // ====================

    // Two half-word units, one cycle to data_out
    mem_branch u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .gate_en (gate_en),
        .data_in (data_in),
        .mem_q   (mem_q)
    );

    // ====================
    // Combining stage
    // ====================

    // IO and control registers plus the output XOR
    ctrl_io_combine u_combine (
        .clk      (clk),
        .rst_n    (rst_n),
        .gate_en  (gate_en),
        .data_in  (data_in),
        .proc_q   (proc_q),
        .mem_q    (mem_q),
        .data_out (data_out)
    );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock source and active-low power-on reset
module tb_clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, low first half
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/tb_multiblock_gating.sv
// Testbench for the gating network: random stimulus, reference model, checks and watchdog
module tb_multiblock_gating import gating_pkg::*; ();

    // ====================
    // Run lengths
    // ====================

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 4;
    localparam int gate_off_cycles = 200;
    localparam int mem_io_cycles   = 400;
    localparam int capture_rounds  = 40;
    localparam int proc_steps      = 5;
    localparam int random_cycles   = 3000;
    localparam int rand_seed       = 32'hc121_c160;

    // Every phase plus the cycle right after reset
    localparam int total_cycles = reset_cycles + 1 + gate_off_cycles + mem_io_cycles
                                + capture_rounds * (proc_steps + 1) + random_cycles;
    localparam int timeout_time = (total_cycles + 50) * clk_period;

    // ====================
    // DUT signals
    // ====================

    logic              clk;
    logic              rst_n;
    gate_en_t          gate_en;
    logic [data_w-1:0] data_in;
    logic [data_w-1:0] data_out;

    // Reference registers
    proc_word_t        m_proc;
    mem_word_t         m_mem;
    logic [data_w-1:0] m_io;
    proc_word_t        m_ctrl;

    int                cycle;
    logic [data_w-1:0] held;

    tb_clock_gen #(
        .period       (clk_period),
        .reset_cycles (reset_cycles)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    multiblock_gating UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .gate_en  (gate_en),
        .data_in  (data_in),
        .data_out (data_out)
    );

    // ====================
    // Reference model
    // ====================

    // Byte i of the bus plus i, wrapped to 8 bits
    function automatic logic [proc_lane_w-1:0] unit_sum(input logic [data_w-1:0] d,
                                                        input int i);
        return proc_lane_w'((d >> (proc_lane_w * i)) + i);
    endfunction

    // Nonblocking updates, so the control capture sees the old units
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_proc <= '0;
            m_mem  <= '0;
            m_io   <= '0;
            m_ctrl <= '0;
        end else if (gate_en.global_en) begin
            if (gate_en.ctrl_en) begin
                m_ctrl <= m_proc;
            end
            if (gate_en.io_en) begin
                m_io <= data_in;
            end
            for (int i = 0; i < proc_lanes; i++) begin
                if (gate_en.proc_en && gate_en.proc_unit_en[i]) begin
                    m_proc.lane[i] <= unit_sum(data_in, i);
                end
            end
            for (int j = 0; j < mem_lanes; j++) begin
                if (gate_en.mem_en && gate_en.mem_unit_en[j]) begin
                    m_mem.lane[j] <= data_in[j*mem_lane_w +: mem_lane_w];
                end
            end
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    // True with the given chance in percent
    function automatic logic chance(input int pct);
        return $urandom_range(99, 0) < pct;
    endfunction

    // Fresh bus word and enables, each bit by its own chance
    task automatic drive_enables(input int p_global, input int p_proc, input int p_mem,
                                 input int p_io, input int p_ctrl, input int p_unit);
        gate_en_t en;
        en.global_en = chance(p_global);
        en.proc_en   = chance(p_proc);
        en.mem_en    = chance(p_mem);
        en.io_en     = chance(p_io);
        en.ctrl_en   = chance(p_ctrl);
        for (int i = 0; i < proc_lanes; i++) begin
            en.proc_unit_en[i] = chance(p_unit);
        end
        for (int j = 0; j < mem_lanes; j++) begin
            en.mem_unit_en[j] = chance(p_unit);
        end
        gate_en = en;
        data_in = $urandom();
    endtask

    task automatic check_value(input logic [data_w-1:0] expected);
        assert (data_out === expected) else
            report_failure($sformatf("MISMATCH data_out expected=%h actual=%h",
                                     expected, data_out));
    endtask

    // Falling edge, outputs settled since the rising edge
    task automatic next_cycle();
        logic [data_w-1:0] expected;
        @(negedge clk);
        cycle++;
        expected = m_ctrl ^ m_io ^ m_mem;
        check_value(expected);
    endtask

    // ====================
    // Watchdog
    // ====================

    initial begin
        #(timeout_time);
        $display("Watchdog expired, the tests did not finish within %0d cycles",
                 total_cycles + 50);
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        cycle   = 0;
        gate_en = '0;
        data_in = '0;
        void'($urandom(rand_seed));

        // Phase 1, reset must win over fully open gates
        drive_enables(100, 100, 100, 100, 100, 100);
        for (int k = 0; k < reset_cycles; k++) begin
            next_cycle();
            assert (rst_n === 1'b0) else
                report_failure("Reset was released before the expected cycle");
            check_value('0);
            if (k == reset_cycles - 1) begin
                // Closed global gate over the first edge after release
                drive_enables(0, 100, 100, 100, 100, 100);
            end else begin
                drive_enables(100, 100, 100, 100, 100, 100);
            end
        end
        next_cycle();
        assert (rst_n === 1'b1) else
            report_failure("Reset is still asserted after the reset period");
        check_value('0);

        // Phase 2, global gate off freezes everything
        held = m_ctrl ^ m_io ^ m_mem;
        for (int k = 0; k < gate_off_cycles; k++) begin
            drive_enables(0, 50, 50, 50, 50, 50);
            next_cycle();
            check_value(held);
        end

        // Phase 3, memory and IO only
        for (int k = 0; k < mem_io_cycles; k++) begin
            drive_enables(100, 0, 90, 60, 0, 50);
            next_cycle();
        end

        // Phase 4, unit loads stay hidden until a control capture
        for (int r = 0; r < capture_rounds; r++) begin
            held = m_ctrl ^ m_io ^ m_mem;
            for (int s = 0; s < proc_steps; s++) begin
                drive_enables(100, 100, 0, 0, 0, 50);
                next_cycle();
                check_value(held);
            end
            drive_enables(100, 0, 0, 0, 100, 0);
            next_cycle();
        end

        // Phase 5, everything random
        for (int k = 0; k < random_cycles; k++) begin
            drive_enables(80, 50, 50, 50, 50, 50);
            next_cycle();
        end

        $display("Checked %0d cycles", cycle);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- multiblock_gating.f
verilog/gating_pkg.sv
verilog/proc_branch.sv
verilog/mem_branch.sv
verilog/ctrl_io_combine.sv
verilog/multiblock_gating.sv
sim/tb_clock_gen.sv
sim/tb_multiblock_gating.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the gating network testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_multiblock_gating \
    -f multiblock_gating.f \
    -o sim_multiblock_gating \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_multiblock_gating > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation passed"
exit 0
